/* Bender.yml */
package:
  name: fsab_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fsab_pkg.sv
      - verilog/fsab_arb_pkg.sv
      - verilog/fsab_ifs.sv
      - verilog/fsab_client_fifo.sv
      - verilog/fsab_arbiter.sv
      - verilog/fsab_mem_target.sv
      - verilog/fsab_subsys.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/fsab_subsys_tb.sv

/* dv/fsab_subsys_tb.sv */
`timescale 1ns/1ps
`include "fsab_params.svh"

module fsab_subsys_tb;
	localparam int NCL = `FSAB_NUM_CLIENTS;
	localparam int NUM_REQ = 40; // Random requests per client.
	localparam int SPAN = 128; // Words owned by one client.
	localparam int TIMEOUT_CYCLES = NUM_REQ * NCL * 60;

	logic                    iclk;
	logic                    iclk_rst_b;
	logic                    oclk;
	logic                    oclk_rst_b;
	logic [NCL-1:0]          inp_valid;
	logic [NCL-1:0]          inp_mode;
	logic [`FSAB_DID_W-1:0]  inp_did [NCL];
	logic [`FSAB_DID_W-1:0]  inp_subdid [NCL];
	logic [`FSAB_ADDR_W-1:0] inp_addr [NCL];
	logic [`FSAB_LEN_W-1:0]  inp_len [NCL];
	logic [`FSAB_DATA_W-1:0] inp_data [NCL];
	logic [`FSAB_MASK_W-1:0] inp_mask [NCL];
	logic [NCL-1:0]          inp_credit;
	logic                    rsp_valid;
	logic [`FSAB_DID_W-1:0]  rsp_did;
	logic [`FSAB_DID_W-1:0]  rsp_subdid;
	logic [`FSAB_DATA_W-1:0] rsp_data;

	logic [`FSAB_DATA_W-1:0] model_mem [2 ** `FSAB_ADDR_W]; // Byte-masked reference memory.
	logic [`FSAB_DATA_W-1:0] exp_words [NCL][$]; // Read data in issue order.
	int                      exp_len [NCL][$];
	logic [`FSAB_DID_W-1:0]  exp_sub [NCL][$];
	int                      eidx [NCL]; // Next read entry to be answered.
	int                      widx [NCL]; // Next expected word.
	int                      used [NCL]; // Credits spent.
	int                      returned [NCL]; // Credit pulses seen.
	int                      rsp_cl;
	int                      rsp_left; // Words still due in the current stream.
	bit                      rsp_prev;
	bit                      started; // First request issued.
	int                      cycle_cnt;

	fsab_subsys UUT (
		.iclk       (iclk),
		.iclk_rst_b (iclk_rst_b),
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.inp_valid  (inp_valid),
		.inp_mode   (inp_mode),
		.inp_did    (inp_did),
		.inp_subdid (inp_subdid),
		.inp_addr   (inp_addr),
		.inp_len    (inp_len),
		.inp_data   (inp_data),
		.inp_mask   (inp_mask),
		.inp_credit (inp_credit),
		.rsp_valid  (rsp_valid),
		.rsp_did    (rsp_did),
		.rsp_subdid (rsp_subdid),
		.rsp_data   (rsp_data)
	);

	initial begin
		oclk = 1'b0;
		forever #5 oclk = ~oclk; // 10 ns.
	end

	initial begin
		iclk = 1'b0;
		forever #7 iclk = ~iclk; // 14 ns period with no fixed phase to oclk.
	end

	task automatic stop_failed();
		$display("Regression failed");
		$fatal(1, "Stopping on the first error");
	endtask

	task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("ERROR at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
		stop_failed();
	endtask

	task automatic fail_text(input string msg);
		$display("%s (at %0t)", msg, $time);
		stop_failed();
	endtask

	// Each client has its own did.
	function automatic logic [`FSAB_DID_W-1:0] did_of(input int c);
		return `FSAB_DID_W'(5 + 5 * c);
	endfunction

	function automatic int client_of(input logic [`FSAB_DID_W-1:0] did);
		client_of = -1; // Unknown did.
		for (int c = 0; c < NCL; c++)
			if (did_of(c) == did)
				client_of = c;
	endfunction

	// Every read of both clients answered in full.
	function automatic bit reads_answered();
		reads_answered = (rsp_left == 0);
		for (int c = 0; c < NCL; c++)
			if (eidx[c] != exp_len[c].size())
				reads_answered = 1'b0;
	endfunction

	task automatic wait_credit(input int c);
		while (used[c] - returned[c] >= `FSAB_INITIAL_CREDITS)
			@(posedge iclk); // Out of credits.
		used[c]++;
		started = 1'b1;
	endtask

	task automatic drive_beat(input int c, input logic mode, input logic [7:0] addr,
		input logic [3:0] len, input logic [3:0] sub, input logic [31:0] data,
		input logic [3:0] mask);
		@(posedge iclk);
		inp_valid[c] <= 1'b1;
		inp_mode[c] <= mode;
		inp_did[c] <= did_of(c);
		inp_subdid[c] <= sub;
		inp_addr[c] <= addr;
		inp_len[c] <= len;
		inp_data[c] <= data;
		inp_mask[c] <= mask;
	endtask

	task automatic drive_idle(input int c);
		@(posedge iclk);
		inp_valid[c] <= 1'b0;
	endtask

	task automatic send_write(input int c, input logic [7:0] addr, input logic [3:0] len);
		logic [31:0] data;
		logic [3:0]  mask;
		logic [7:0]  waddr;
		wait_credit(c); // One credit for the whole burst.
		for (int k = 0; k < len; k++) begin
			data = $urandom();
			// Full word half the time and a partial mask otherwise.
			mask = ($urandom() % 2 == 0) ? 4'hf : 4'($urandom() % 14) + 4'd1;
			waddr = addr + 8'(k);
			for (int b = 0; b < `FSAB_MASK_W; b++)
				if (mask[b])
					model_mem[waddr][8*b +: 8] = data[8*b +: 8];
			if (k > 0 && $urandom() % 4 == 0)
				drive_idle(c); // Gap inside the burst.
			drive_beat(c, 1'b1, addr, len, 4'h0, data, mask);
		end
		drive_idle(c);
	endtask

	task automatic send_read(input int c, input logic [7:0] addr, input logic [3:0] len,
		input logic [3:0] tag);
		wait_credit(c);
		// Earlier writes of this client are already in the model.
		for (int k = 0; k < len; k++)
			exp_words[c].push_back(model_mem[addr + 8'(k)]);
		exp_len[c].push_back(len);
		exp_sub[c].push_back(tag);
		drive_beat(c, 1'b0, addr, len, tag, $urandom(), 4'h0);
		drive_idle(c);
	endtask

	task automatic run_client(input int c);
		logic [3:0] len;
		logic [7:0] addr;
		logic [3:0] tag;
		tag = 4'h0; // Read sequence number that goes out as subdid.
		for (int n = 0; n < NUM_REQ; n++) begin
			len = 4'(1 + $urandom() % `FSAB_LEN_MAX);
			addr = 8'(c * SPAN + $urandom() % (SPAN + 1 - len)); // Burst stays in range.
			if ($urandom() % 2 == 0) begin
				send_write(c, addr, len);
			end else begin
				send_read(c, addr, len, tag);
				tag++;
			end
		end
		// Read back the whole range.
		for (int a = 0; a < SPAN; a += `FSAB_LEN_MAX) begin
			send_read(c, 8'(c * SPAN + a), `FSAB_LEN_W'(`FSAB_LEN_MAX), tag);
			tag++;
		end
	endtask

	// Credit pulses are sampled mid-cycle.
	always @(negedge iclk) begin
		if (iclk_rst_b) begin
			for (int c = 0; c < NCL; c++) begin
				if (!started) begin
					assert (inp_credit[c] == 1'b0) else fail_value("inp_credit", inp_credit[c], 0);
				end
				if (inp_credit[c]) begin
					returned[c]++;
					assert (returned[c] <= used[c])
						else fail_text("A credit came back with no request outstanding");
				end
			end
		end
	end

	// Read responses.
	always @(negedge oclk) begin
		if (oclk_rst_b) begin
			if (!started) begin
				assert (rsp_valid == 1'b0) else fail_value("rsp_valid", rsp_valid, 0);
			end
			if (rsp_valid && rsp_left == 0) begin // First word of a stream.
				assert (!rsp_prev) else fail_text("Read response ran past its length");
				rsp_cl = client_of(rsp_did);
				assert (rsp_cl >= 0) else fail_text("Response carries an unknown did");
				assert (eidx[rsp_cl] < exp_len[rsp_cl].size())
					else fail_text("Response arrived with no read outstanding");
				assert (rsp_subdid == exp_sub[rsp_cl][eidx[rsp_cl]])
					else fail_value("rsp_subdid", rsp_subdid, exp_sub[rsp_cl][eidx[rsp_cl]]);
				rsp_left = exp_len[rsp_cl][eidx[rsp_cl]];
				eidx[rsp_cl]++;
			end
			if (rsp_valid) begin
				assert (rsp_did == did_of(rsp_cl)) else fail_value("rsp_did", rsp_did, did_of(rsp_cl));
				assert (rsp_data == exp_words[rsp_cl][widx[rsp_cl]])
					else fail_value("rsp_data", rsp_data, exp_words[rsp_cl][widx[rsp_cl]]);
				widx[rsp_cl]++;
				rsp_left--;
			end else begin
				assert (rsp_left == 0) else fail_text("Read response stream broke off early");
			end
			rsp_prev = rsp_valid;
		end
	end

	always @(posedge oclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			fail_text($sformatf("Timeout, run still busy after %0d oclk cycles", TIMEOUT_CYCLES));
	end

	initial begin
		void'($urandom(32'hc09141e4));
		for (int a = 0; a < 2 ** `FSAB_ADDR_W; a++)
			model_mem[a] = '0; // Target memory resets to zero.
		iclk_rst_b = 1'b0;
		oclk_rst_b = 1'b0;
		inp_valid = '0;
		inp_mode = '0;
		for (int c = 0; c < NCL; c++) begin
			inp_did[c] = '0;
			inp_subdid[c] = '0;
			inp_addr[c] = '0;
			inp_len[c] = '0;
			inp_data[c] = '0;
			inp_mask[c] = '0;
		end
		repeat (3) @(posedge oclk);
		oclk_rst_b <= 1'b1;
		@(posedge iclk);
		iclk_rst_b <= 1'b1;
		repeat (20) @(posedge iclk); // Idle outputs must stay low here.
		fork
			run_client(0);
			run_client(1);
		join
		while (!reads_answered())
			@(posedge oclk);
		repeat (50) @(posedge iclk); // Window for the last credits and stray responses.
		for (int c = 0; c < NCL; c++) begin
			assert (`FSAB_INITIAL_CREDITS - used[c] + returned[c] == `FSAB_INITIAL_CREDITS)
				else fail_value("credits", `FSAB_INITIAL_CREDITS - used[c] + returned[c],
					`FSAB_INITIAL_CREDITS);
		end
		$display("Regression passed");
		$finish;
	end
endmodule

/* sources.f */
+incdir+verilog
verilog/fsab_pkg.sv
verilog/fsab_arb_pkg.sv
verilog/fsab_ifs.sv
verilog/fsab_client_fifo.sv
verilog/fsab_arbiter.sv
verilog/fsab_mem_target.sv
verilog/fsab_subsys.sv
dv/fsab_subsys_tb.sv

/* verilog/fsab_arb_pkg.sv */
`include "fsab_params.svh"

package fsab_arb_pkg;

	typedef logic [$clog2(`FSAB_NUM_CLIENTS)-1:0] fsab_client_idx_t;

	typedef enum logic [1:0] {
		ARB_IDLE, // Looking for a client with a request.
		ARB_START, // Pulsing start_trans.
		ARB_BUSY // Waiting for the client to go inactive.
	} fsab_arb_state_t;

endpackage

/* verilog/fsab_arbiter.sv */
`timescale 1ns/1ps
`include "fsab_params.svh"

module fsab_arbiter
	import fsab_pkg::*;
	import fsab_arb_pkg::*;
(
	input  logic       oclk,
	input  logic       oclk_rst_b,
	fsab_client_if.arb cl [`FSAB_NUM_CLIENTS],
	fsab_bus_if.master bus
);
	logic [`FSAB_NUM_CLIENTS-1:0] cl_empty_b;
	logic [`FSAB_NUM_CLIENTS-1:0] cl_active;
	logic [`FSAB_NUM_CLIENTS-1:0] cl_valid;
	fsab_hdr_t                    cl_hdr [`FSAB_NUM_CLIENTS];
	fsab_beat_t                   cl_beat [`FSAB_NUM_CLIENTS];
	fsab_arb_state_t              state;
	fsab_client_idx_t             grant; // Also the last client served.
	fsab_client_idx_t             pick;
	fsab_client_idx_t             cand;
	logic                         pick_ok;

	for (genvar i = 0; i < `FSAB_NUM_CLIENTS; i++) begin : g_cl
		assign cl_empty_b[i] = cl[i].empty_b;
		assign cl_active[i] = cl[i].active;
		assign cl_valid[i] = cl[i].out_valid;
		assign cl_hdr[i] = cl[i].out_hdr;
		assign cl_beat[i] = cl[i].out_beat;
		assign cl[i].start_trans = (state == ARB_START) && (grant == fsab_client_idx_t'(i));
	end

	// Round robin, the search starts just past the last grant.
	always_comb begin
		pick = grant;
		pick_ok = 1'b0;
		cand = grant;
		for (int k = 1; k <= `FSAB_NUM_CLIENTS; k++) begin
			cand = fsab_client_idx_t'((int'(grant) + k) % `FSAB_NUM_CLIENTS);
			if (!pick_ok && cl_empty_b[cand]) begin
				pick = cand;
				pick_ok = 1'b1;
			end
		end
	end

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			state <= ARB_IDLE;
			grant <= fsab_client_idx_t'(`FSAB_NUM_CLIENTS - 1); // Client 0 is first.
		end else begin
			unique case (state)
				ARB_IDLE: begin
					if (pick_ok && bus.ready) begin // Target can take a request.
						grant <= pick;
						state <= ARB_START;
					end
				end
				ARB_START: state <= ARB_BUSY;
				ARB_BUSY: begin
					if (!cl_active[grant])
						state <= ARB_IDLE; // Last beat is out.
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign bus.valid = (state == ARB_BUSY) && cl_valid[grant];
	assign bus.hdr = cl_hdr[grant];
	assign bus.beat = cl_beat[grant];
endmodule

/* verilog/fsab_client_fifo.sv */
`timescale 1ns/1ps
`include "fsab_params.svh"

module fsab_client_fifo
	import fsab_pkg::*;
(
	input  logic        iclk,
	input  logic        iclk_rst_b,
	input  logic        oclk,
	input  logic        oclk_rst_b,
	input  logic        inp_valid,
	input  fsab_hdr_t   inp_hdr, // Meaningful on the first beat only.
	input  fsab_beat_t  inp_beat,
	output logic        inp_credit,
	fsab_client_if.fifo cl
);
	localparam int RIDX_W = $clog2(`FSAB_INITIAL_CREDITS);
	localparam int DIDX_W = $clog2(`FSAB_DFIF_DEPTH);
	localparam int DPTR_W = DIDX_W + 1; // Extra wrap bit.
	localparam int CW = `FSAB_CREDITS_W;

	fsab_hdr_t  rfif_mem [`FSAB_INITIAL_CREDITS];
	fsab_beat_t dfif_mem [`FSAB_DFIF_DEPTH];

	logic [CW-1:0]     rfif_wpos; // iclk side.
	logic [CW-1:0]     rfif_wpos_next;
	logic [CW-1:0]     rfif_wpos_g;
	logic [CW-1:0]     rfif_wpos_g_s1; // oclk side from here.
	logic [CW-1:0]     rfif_wpos_g_o;
	logic [CW-1:0]     rfif_rpos;
	logic [DPTR_W-1:0] dfif_wpos; // iclk side.
	logic [DPTR_W-1:0] dfif_wpos_next;
	logic [DPTR_W-1:0] dfif_wpos_g;
	logic [DPTR_W-1:0] dfif_wpos_g_s1; // oclk side from here.
	logic [DPTR_W-1:0] dfif_wpos_g_o;
	logic [DPTR_W-1:0] dfif_rpos;
	logic              rfif_wr;
	logic              rfif_rd;
	logic              dfif_rd;
	logic              rfif_empty;
	logic              dfif_empty;
	logic [`FSAB_LEN_W-1:0] in_rem; // Beats left of the incoming write.
	logic [`FSAB_LEN_W-1:0] out_rem; // Beats left to present.
	logic              rfif_rd_1a;
	logic              dfif_rd_1a;
	logic              act_0a;
	logic              act_1a;
	fsab_hdr_t         hdr_1a;
	fsab_beat_t        beat_1a;
	logic              cred_rel;
	logic [CW-1:0]     cred_cnt_o;
	logic [CW-1:0]     cred_cnt_o_next;
	logic [CW-1:0]     cred_g_o; // Flopped in oclk so the crossing sees no glitch.
	logic [CW-1:0]     cred_g_s1;
	logic [CW-1:0]     cred_g_i;
	logic [CW-1:0]     cred_cnt_i;

	// Only a beat that opens a request writes a header.
	assign rfif_wr = inp_valid && (in_rem <= `FSAB_LEN_W'(1));
	assign rfif_wpos_next = rfif_wpos + CW'(rfif_wr);
	assign dfif_wpos_next = dfif_wpos + DPTR_W'(inp_valid); // Every beat, reads too.

	always_ff @(posedge iclk or negedge iclk_rst_b) begin
		if (!iclk_rst_b) begin
			rfif_wpos <= '0;
			rfif_wpos_g <= '0;
			dfif_wpos <= '0;
			dfif_wpos_g <= '0;
			in_rem <= '0;
			cred_g_s1 <= '0;
			cred_g_i <= '0;
			cred_cnt_i <= '0;
		end else begin
			rfif_wpos <= rfif_wpos_next;
			rfif_wpos_g <= rfif_wpos_next ^ (rfif_wpos_next >> 1);
			dfif_wpos <= dfif_wpos_next;
			dfif_wpos_g <= dfif_wpos_next ^ (dfif_wpos_next >> 1);
			if (rfif_wr && inp_hdr.mode == FSAB_WRITE)
				in_rem <= inp_hdr.len; // Header beat counts as the first.
			else if (inp_valid && in_rem != '0)
				in_rem <= in_rem - 1'b1;
			cred_g_s1 <= cred_g_o; // Two flops against metastability.
			cred_g_i <= cred_g_s1;
			if (inp_credit)
				cred_cnt_i <= cred_cnt_i + 1'b1; // Catch up one credit per cycle.
		end
	end

	always_ff @(posedge iclk) begin
		if (rfif_wr)
			rfif_mem[rfif_wpos[RIDX_W-1:0]] <= inp_hdr;
		if (inp_valid)
			dfif_mem[dfif_wpos[DIDX_W-1:0]] <= inp_beat;
	end

	// Write pointers lag, so a FIFO may look empty too long but never too short.
	assign rfif_empty = (rfif_rpos ^ (rfif_rpos >> 1)) == rfif_wpos_g_o;
	assign dfif_empty = (dfif_rpos ^ (dfif_rpos >> 1)) == dfif_wpos_g_o;

	// The first beat lands with the header, so both must be visible.
	assign cl.empty_b = !rfif_empty && !dfif_empty;
	assign rfif_rd = !rfif_empty && !dfif_empty && cl.start_trans && !act_0a && !rfif_rd_1a;
	// The data FIFO is popped with every header, then for the rest of a write.
	assign dfif_rd = rfif_rd ||
		(act_0a && hdr_1a.mode == FSAB_WRITE && out_rem > `FSAB_LEN_W'(1) && !dfif_empty);

	// Credit goes back once the last beat has left, or right away for a read.
	assign cred_rel = (act_1a && !act_0a) || (rfif_rd_1a && hdr_1a.mode == FSAB_READ);
	assign cred_cnt_o_next = cred_cnt_o + CW'(cred_rel);

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			rfif_wpos_g_s1 <= '0;
			rfif_wpos_g_o <= '0;
			dfif_wpos_g_s1 <= '0;
			dfif_wpos_g_o <= '0;
			rfif_rpos <= '0;
			dfif_rpos <= '0;
			rfif_rd_1a <= 1'b0;
			dfif_rd_1a <= 1'b0;
			act_0a <= 1'b0;
			act_1a <= 1'b0;
			out_rem <= '0;
			cred_cnt_o <= '0;
			cred_g_o <= '0;
		end else begin
			rfif_wpos_g_s1 <= rfif_wpos_g;
			rfif_wpos_g_o <= rfif_wpos_g_s1;
			dfif_wpos_g_s1 <= dfif_wpos_g;
			dfif_wpos_g_o <= dfif_wpos_g_s1;
			if (rfif_rd)
				rfif_rpos <= rfif_rpos + 1'b1;
			if (dfif_rd)
				dfif_rpos <= dfif_rpos + 1'b1;
			rfif_rd_1a <= rfif_rd;
			dfif_rd_1a <= dfif_rd;
			act_1a <= act_0a;
			if (rfif_rd_1a && hdr_1a.mode == FSAB_WRITE) begin
				act_0a <= 1'b1; // Header just arrived, present the rest.
				out_rem <= hdr_1a.len;
			end else if (dfif_rd && act_0a) begin
				out_rem <= out_rem - 1'b1;
			end else if (out_rem <= `FSAB_LEN_W'(1)) begin
				act_0a <= 1'b0;
			end
			cred_cnt_o <= cred_cnt_o_next;
			cred_g_o <= cred_cnt_o_next ^ (cred_cnt_o_next >> 1);
		end
	end

	always_ff @(posedge oclk) begin
		if (rfif_rd)
			hdr_1a <= rfif_mem[rfif_rpos[RIDX_W-1:0]];
		if (dfif_rd)
			beat_1a <= dfif_mem[dfif_rpos[DIDX_W-1:0]];
	end

	assign inp_credit = cred_g_i != (cred_cnt_i ^ (cred_cnt_i >> 1));

	assign cl.active = act_1a || act_0a || rfif_rd_1a;
	assign cl.out_valid = dfif_rd_1a;
	assign cl.out_hdr = hdr_1a;
	assign cl.out_beat = beat_1a;
endmodule

/* verilog/fsab_ifs.sv */
`timescale 1ns/1ps

// Client FIFO to arbiter, all on oclk.
interface fsab_client_if
	import fsab_pkg::*;
();
	logic       empty_b; // A whole request head is buffered.
	logic       active; // A request is being presented.
	logic       out_valid;
	fsab_hdr_t  out_hdr;
	fsab_beat_t out_beat;
	logic       start_trans; // One cycle pulse from the arbiter.

	modport fifo (
		output empty_b, active, out_valid, out_hdr, out_beat,
		input  start_trans
	);

	modport arb (
		input  empty_b, active, out_valid, out_hdr, out_beat,
		output start_trans
	);
endinterface

// Shared bus from arbiter to memory target.
interface fsab_bus_if
	import fsab_pkg::*;
();
	logic       valid; // One beat per cycle.
	fsab_hdr_t  hdr; // Held for every beat of a write.
	fsab_beat_t beat;
	logic       ready; // Low while read data streams back.

	modport master (output valid, hdr, beat, input ready);
	modport target (input valid, hdr, beat, output ready);
endinterface

/* verilog/fsab_mem_target.sv */
`timescale 1ns/1ps
`include "fsab_params.svh"

module fsab_mem_target
	import fsab_pkg::*;
(
	input  logic                   oclk,
	input  logic                   oclk_rst_b,
	fsab_bus_if.target             bus,
	output logic                   rsp_valid,
	output logic [`FSAB_DID_W-1:0] rsp_did,
	output logic [`FSAB_DID_W-1:0] rsp_subdid,
	output logic [`FSAB_DATA_W-1:0] rsp_data
);
	localparam int AW = `FSAB_ADDR_W;
	localparam int WORDS = 2 ** AW;

	logic [`FSAB_DATA_W-1:0] mem [WORDS];
	logic [`FSAB_LEN_W-1:0]  wr_cnt; // Beat index inside the current write.
	logic [AW-1:0]           wr_addr;
	logic [`FSAB_LEN_W-1:0]  rd_rem; // Responses still to send after this one.
	logic [AW-1:0]           rd_addr;
	logic                    rd_busy;
	logic                    wr_beat;
	logic                    rd_beat;

	assign bus.ready = !rd_busy;
	assign wr_beat = bus.valid && bus.hdr.mode == FSAB_WRITE;
	assign rd_beat = bus.valid && bus.hdr.mode == FSAB_READ && !rd_busy;
	assign wr_addr = bus.hdr.addr + AW'(wr_cnt);

	always_ff @(posedge oclk or negedge oclk_rst_b) begin
		if (!oclk_rst_b) begin
			for (int i = 0; i < WORDS; i++)
				mem[i] <= '0;
			wr_cnt <= '0;
			rd_rem <= '0;
			rd_busy <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			if (wr_beat) begin
				for (int b = 0; b < `FSAB_MASK_W; b++)
					if (bus.beat.mask[b])
						mem[wr_addr][8*b +: 8] <= bus.beat.data[8*b +: 8];
				// Back to zero on the last beat of the burst.
				wr_cnt <= (wr_cnt == bus.hdr.len - 1'b1) ? '0 : wr_cnt + 1'b1;
			end
			if (rd_beat) begin
				rd_busy <= 1'b1; // Holds ready low until the stream ends.
				rsp_valid <= 1'b1;
				rd_rem <= bus.hdr.len - 1'b1;
			end else if (rd_busy) begin
				rsp_valid <= rd_rem != '0;
				rd_busy <= rd_rem != '0;
				if (rd_rem != '0)
					rd_rem <= rd_rem - 1'b1;
			end
		end
	end

	// Response payload, first word straight from the read beat.
	always_ff @(posedge oclk) begin
		if (rd_beat) begin
			rsp_data <= mem[bus.hdr.addr];
			rd_addr <= bus.hdr.addr + 1'b1;
			rsp_did <= bus.hdr.did; // Tag with the requester.
			rsp_subdid <= bus.hdr.subdid;
		end else if (rd_busy && rd_rem != '0) begin
			rsp_data <= mem[rd_addr];
			rd_addr <= rd_addr + 1'b1;
		end
	end
endmodule

/* verilog/fsab_params.svh */
`ifndef FSAB_PARAMS_SVH
`define FSAB_PARAMS_SVH

// Clients sharing the bus.
`define FSAB_NUM_CLIENTS 2

`define FSAB_DID_W  4 // Device and sub-device id.
`define FSAB_ADDR_W 8 // Word address.
`define FSAB_LEN_W  4 // Burst length field.
`define FSAB_LEN_MAX 8 // Longest burst in beats.
`define FSAB_DATA_W 32
`define FSAB_MASK_W 4 // One enable per data byte.

// Requests a client may have in flight.
`define FSAB_INITIAL_CREDITS 4
`define FSAB_CREDITS_W 3 // One wrap bit over the request FIFO index.

// Enough beats for every credit to carry a full burst.
`define FSAB_DFIF_DEPTH (`FSAB_INITIAL_CREDITS * `FSAB_LEN_MAX)

`endif

/* verilog/fsab_pkg.sv */
`include "fsab_params.svh"

package fsab_pkg;

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	// Request header, one request FIFO entry.
	typedef struct packed {
		fsab_mode_t               mode;
		logic [`FSAB_DID_W-1:0]   did;
		logic [`FSAB_DID_W-1:0]   subdid;
		logic [`FSAB_ADDR_W-1:0]  addr; // First word of the burst.
		logic [`FSAB_LEN_W-1:0]   len; // Beats in the burst.
	} fsab_hdr_t;

	// One data FIFO entry.
	typedef struct packed {
		logic [`FSAB_DATA_W-1:0]  data;
		logic [`FSAB_MASK_W-1:0]  mask; // Bit b enables byte b.
	} fsab_beat_t;

endpackage

/* verilog/fsab_subsys.sv */
`timescale 1ns/1ps
`include "fsab_params.svh"

module fsab_subsys
	import fsab_pkg::*;
(
	input  logic                          iclk,
	input  logic                          iclk_rst_b,
	input  logic                          oclk,
	input  logic                          oclk_rst_b,
	input  logic [`FSAB_NUM_CLIENTS-1:0]  inp_valid,
	input  logic [`FSAB_NUM_CLIENTS-1:0]  inp_mode, // 1 is a write.
	input  logic [`FSAB_DID_W-1:0]        inp_did [`FSAB_NUM_CLIENTS],
	input  logic [`FSAB_DID_W-1:0]        inp_subdid [`FSAB_NUM_CLIENTS],
	input  logic [`FSAB_ADDR_W-1:0]       inp_addr [`FSAB_NUM_CLIENTS],
	input  logic [`FSAB_LEN_W-1:0]        inp_len [`FSAB_NUM_CLIENTS],
	input  logic [`FSAB_DATA_W-1:0]       inp_data [`FSAB_NUM_CLIENTS],
	input  logic [`FSAB_MASK_W-1:0]       inp_mask [`FSAB_NUM_CLIENTS],
	output logic [`FSAB_NUM_CLIENTS-1:0]  inp_credit, // iclk, one pulse per credit.
	output logic                          rsp_valid,
	output logic [`FSAB_DID_W-1:0]        rsp_did,
	output logic [`FSAB_DID_W-1:0]        rsp_subdid,
	output logic [`FSAB_DATA_W-1:0]       rsp_data
);
	fsab_client_if cl_if [`FSAB_NUM_CLIENTS] ();
	fsab_bus_if    bus_if ();

	for (genvar i = 0; i < `FSAB_NUM_CLIENTS; i++) begin : g_client
		fsab_hdr_t  hdr;
		fsab_beat_t beat;

		assign hdr = '{
			mode:   fsab_mode_t'(inp_mode[i]),
			did:    inp_did[i],
			subdid: inp_subdid[i],
			addr:   inp_addr[i],
			len:    inp_len[i]
		};
		assign beat = '{data: inp_data[i], mask: inp_mask[i]};

		fsab_client_fifo u_fifo (
			.iclk       (iclk),
			.iclk_rst_b (iclk_rst_b),
			.oclk       (oclk),
			.oclk_rst_b (oclk_rst_b),
			.inp_valid  (inp_valid[i]),
			.inp_hdr    (hdr),
			.inp_beat   (beat),
			.inp_credit (inp_credit[i]),
			.cl         (cl_if[i])
		);
	end

	fsab_arbiter u_arb (
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.cl         (cl_if),
		.bus        (bus_if)
	);

	fsab_mem_target u_mem (
		.oclk       (oclk),
		.oclk_rst_b (oclk_rst_b),
		.bus        (bus_if),
		.rsp_valid  (rsp_valid),
		.rsp_did    (rsp_did),
		.rsp_subdid (rsp_subdid),
		.rsp_data   (rsp_data)
	);
endmodule
